//--- rtl/lca_pkg.sv
`default_nettype none

package lca_pkg;

    typedef logic [31:0] block_t;                        // One cipher block, also seed, poly, masks
    typedef logic [15:0] half_t;                         // One Feistel half or round key
    typedef logic [23:0] count_t;                        // Message count and tally width

    // 4-bit PRESENT S-box
    function automatic logic [3:0] sbox4(input logic [3:0] x);
        logic [3:0] y;
        case (x)
            4'h0: y = 4'hc;
            4'h1: y = 4'h5;
            4'h2: y = 4'h6;
            4'h3: y = 4'hb;
            4'h4: y = 4'h9;
            4'h5: y = 4'h0;
            4'h6: y = 4'ha;
            4'h7: y = 4'hd;
            4'h8: y = 4'h3;
            4'h9: y = 4'he;
            4'ha: y = 4'hf;
            4'hb: y = 4'h8;
            4'hc: y = 4'h4;
            4'hd: y = 4'h7;
            4'he: y = 4'h1;
            default: y = 4'h2;
        endcase
        return y;
    endfunction

    // Round function: key mix, nibble substitution, rotate left by 3
    function automatic half_t round_f(input half_t r, input half_t k);
        half_t t;
        half_t s;
        t = r ^ k;                                       // Key mix
        for (int i = 0; i < 4; i++) begin
            s[4*i +: 4] = sbox4(t[4*i +: 4]);            // Per-nibble substitution
        end
        return {s[12:0], s[15:13]};                      // Rotate left by 3
    endfunction

    // Key schedule: pick 16-bit slice (idx mod 4), slice 0 at the LSBs
    function automatic half_t round_key(input logic [63:0] key, input int unsigned idx);
        int unsigned sel;
        sel = idx % 4;
        return key[16*sel +: 16];
    endfunction

endpackage

`default_nettype wire

//--- rtl/pair_if.sv
`timescale 1ns/1ps
`default_nettype none

// Plaintext/ciphertext stream, one pair per clock while valid is high
interface pair_if;

    logic             valid;                             // Pair present this cycle
    logic             last;                              // Final pair of the run, only with valid
    lca_pkg::block_t  plain;                             // Plaintext
    lca_pkg::block_t  cipher;                            // Ciphertext, zero before the cipher

    modport src (
        output valid,
        output last,
        output plain,
        output cipher
    );

    modport dst (
        input  valid,
        input  last,
        input  plain,
        input  cipher
    );

endinterface

`default_nettype wire

//--- rtl/lca_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lca_ctrl (
    input  logic clk,
    input  logic rst_n,                                  // Sync reset, active low
    input  logic start,                                  // Host start request
    input  logic restart,                                // Abort run / clear done
    output logic launch,                                 // One-cycle kick to the message source
    output logic done,                                   // Run complete, count is final
    pair_if.dst  tail                                    // Cipher output stream
);

    typedef enum logic [1:0] {
        idle,
        running,
        finished
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            state <= idle;                               // Reset and restart both return to idle
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;                               // Hold by default
        case (state)
            idle: begin
                if (start) begin
                    state_nxt = running;                 // Launch goes out this same cycle
                end
            end
            running: begin
                if (tail.valid && tail.last) begin
                    state_nxt = finished;                // Last pair has left the pipeline
                end
            end
            finished: begin
                state_nxt = finished;                    // Stay until restart, start ignored
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    assign launch = (state == idle) && start;            // Sampled by the source on the same edge
    assign done   = (state == finished);

    // A new run only starts with the cipher pipeline drained
    a_launch_drained: assert property (
        @(posedge clk) disable iff (!rst_n)
        launch |-> !tail.valid
    );

endmodule

`default_nettype wire

//--- rtl/msg_source.sv
`timescale 1ns/1ps
`default_nettype none

module msg_source (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            restart,
    input  logic            launch,                      // Load seed and count, start emitting
    input  lca_pkg::block_t seed,                        // First plaintext of the run
    input  lca_pkg::block_t poly,                        // Galois feedback taps
    input  lca_pkg::count_t msg_count,                   // Messages per run, 0 means 2^24
    pair_if.src             out                          // Plaintext stream into the cipher
);

    lca_pkg::block_t lfsr_q;                             // Current plaintext
    lca_pkg::block_t poly_q;                             // Taps held for the whole run
    lca_pkg::count_t remaining_q;                        // Messages still to come after this one
    logic            valid_q;
    logic            last_q;

    // Control flags
    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            valid_q     <= 1'b0;
            last_q      <= 1'b0;
            remaining_q <= '0;
        end else if (launch) begin
            valid_q     <= 1'b1;
            last_q      <= (msg_count == 24'd1);         // Single-message run
            remaining_q <= msg_count - 24'd1;            // Wraps to all ones for 2^24
        end else if (valid_q) begin
            if (last_q) begin
                valid_q <= 1'b0;                         // Stream ends after the last pair
                last_q  <= 1'b0;
            end else begin
                remaining_q <= remaining_q - 24'd1;
                last_q      <= (remaining_q == 24'd1);   // Next one is the final message
            end
        end
    end

    // LFSR payload, no reset needed
    always_ff @(posedge clk) begin
        if (launch) begin
            lfsr_q <= seed;                              // Message 0 is the seed itself
            poly_q <= poly;
        end else if (valid_q) begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? poly_q : '0); // Galois step, shift right
        end
    end

    assign out.valid  = valid_q;
    assign out.last   = last_q;
    assign out.plain  = lfsr_q;
    assign out.cipher = '0;                              // Not yet encrypted

    // last is a registered flag, must never stand alone
    a_last_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        out.last |-> out.valid
    );

endmodule

`default_nettype wire

//--- rtl/feistel_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module feistel_pipe #(
    parameter int          ROUNDS = 4,                   // Pipeline stages, one round each
    parameter logic [63:0] KEY    = 64'h0                // Cipher key
) (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,                                // Flush the in-flight pairs
    pair_if.dst  in,                                     // Plaintext stream
    pair_if.src  out                                     // Plaintext/ciphertext stream
);

    for (genvar i = 0; i < ROUNDS; i++) begin : g_round

        logic            valid_d;                        // Stage inputs
        logic            last_d;
        lca_pkg::block_t plain_d;
        lca_pkg::half_t  left_d;
        lca_pkg::half_t  right_d;

        logic            valid_q;                        // Stage registers
        logic            last_q;
        lca_pkg::block_t plain_q;
        lca_pkg::half_t  left_q;
        lca_pkg::half_t  right_q;

        if (i == 0) begin : g_head
            assign valid_d = in.valid;
            assign last_d  = in.last;
            assign plain_d = in.plain;
            assign left_d  = in.plain[31:16];            // Left half is the high half
            assign right_d = in.plain[15:0];
        end else begin : g_link
            assign valid_d = g_round[i-1].valid_q;       // Chain from the previous stage
            assign last_d  = g_round[i-1].last_q;
            assign plain_d = g_round[i-1].plain_q;
            assign left_d  = g_round[i-1].left_q;
            assign right_d = g_round[i-1].right_q;
        end

        // Flags, cleared by reset and restart
        always_ff @(posedge clk) begin
            if (!rst_n || restart) begin
                valid_q <= 1'b0;
                last_q  <= 1'b0;
            end else begin
                valid_q <= valid_d;
                last_q  <= last_d;
            end
        end

        // One Feistel round per stage
        always_ff @(posedge clk) begin
            plain_q <= plain_d;                          // Plaintext rides along for the tally
            left_q  <= right_d;
            right_q <= left_d ^ lca_pkg::round_f(right_d, lca_pkg::round_key(KEY, i));
        end

    end

    assign out.valid  = g_round[ROUNDS-1].valid_q;
    assign out.last   = g_round[ROUNDS-1].last_q;
    assign out.plain  = g_round[ROUNDS-1].plain_q;
    assign out.cipher = {g_round[ROUNDS-1].left_q, g_round[ROUNDS-1].right_q}; // No final swap

    // Every pair entering comes out exactly ROUNDS cycles later
    a_latency_fwd: assert property (
        @(posedge clk) disable iff (!rst_n || restart)
        in.valid |-> ##ROUNDS out.valid
    );

    // And nothing comes out that did not go in
    a_latency_bwd: assert property (
        @(posedge clk) disable iff (!rst_n)
        out.valid |-> $past(in.valid, ROUNDS)
    );

endmodule

`default_nettype wire

//--- rtl/parity_tally.sv
`timescale 1ns/1ps
`default_nettype none

module parity_tally (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            restart,                     // Clear the count
    input  lca_pkg::block_t mask_in,                     // Plaintext bit selection
    input  lca_pkg::block_t mask_out,                    // Ciphertext bit selection
    pair_if.dst             pairs,                       // Pairs out of the cipher
    output lca_pkg::count_t count                        // Pairs with odd combined parity
);

    logic            par_in;                             // Parity of masked plaintext
    logic            par_out;                            // Parity of masked ciphertext
    logic            hit;                                // Linear approximation holds as one
    lca_pkg::count_t count_q;

    assign par_in  = ^(pairs.plain & mask_in);
    assign par_out = ^(pairs.cipher & mask_out);
    assign hit     = pairs.valid && (par_in ^ par_out);

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            count_q <= '0;
        end else if (hit) begin
            count_q <= count_q + 24'd1;                  // Wraps at 2^24
        end
    end

    assign count = count_q;

endmodule

`default_nettype wire

//--- rtl/lca_top.sv
`timescale 1ns/1ps
`default_nettype none

module lca_top #(
    parameter int          ROUNDS = 4,                   // Feistel stages
    parameter logic [63:0] KEY    = 64'h0                // Cipher key
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,                       // Begin a run from idle
    input  logic            restart,                     // Abort and clear
    input  lca_pkg::block_t seed,
    input  lca_pkg::block_t poly,
    input  lca_pkg::block_t mask_in,
    input  lca_pkg::block_t mask_out,
    input  lca_pkg::count_t msg_count,                   // 0 runs 2^24 messages
    output lca_pkg::count_t count,
    output logic            done
);

    logic launch;                                        // Controller to source kick

    pair_if src_bus ();                                  // Source to cipher
    pair_if out_bus ();                                  // Cipher to tally and controller

    lca_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .restart (restart),
        .launch  (launch),
        .done    (done),
        .tail    (out_bus.dst)
    );

    msg_source u_source (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .launch    (launch),
        .seed      (seed),
        .poly      (poly),
        .msg_count (msg_count),
        .out       (src_bus.src)
    );

    feistel_pipe #(
        .ROUNDS (ROUNDS),
        .KEY    (KEY)
    ) u_cipher (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (restart),
        .in      (src_bus.dst),
        .out     (out_bus.src)
    );

    parity_tally u_tally (
        .clk      (clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .mask_in  (mask_in),
        .mask_out (mask_out),
        .pairs    (out_bus.dst),
        .count    (count)
    );

endmodule

`default_nettype wire

//--- tests/lca_ref.svh
`ifndef LCA_REF_SVH
`define LCA_REF_SVH

// Expected-value model of the sampling engine

// PRESENT S-box, one nibble per input value, entry 0 in the low nibble
localparam logic [63:0] SBOX_TABLE = 64'h2174_8fe3_da09_b65c;

// Galois LFSR step, shift right and fold the taps in on a one
function automatic logic [31:0] galois_next(input logic [31:0] s, input logic [31:0] taps);
    return s[0] ? ((s >> 1) ^ taps) : (s >> 1);
endfunction

// Key mix, S-box on every nibble, rotate left by 3
function automatic logic [15:0] mix_half(input logic [15:0] r, input logic [15:0] k);
    logic [15:0] x;
    logic [15:0] y;
    x = r ^ k;
    for (int n = 0; n < 4; n++) begin
        y[4*n +: 4] = SBOX_TABLE[{x[4*n +: 4], 2'b00} +: 4];
    end
    return (y << 3) | (y >> 13);
endfunction

// Toy Feistel cipher, left half high and no final swap
function automatic logic [31:0] encrypt_block(input logic [31:0] p, input int rounds,
                                              input logic [63:0] key);
    logic [15:0] l;
    logic [15:0] r;
    logic [15:0] t;
    l = p[31:16];
    r = p[15:0];
    for (int i = 0; i < rounds; i++) begin
        t = l ^ mix_half(r, key[16*(i%4) +: 16]);        // Key slice i mod 4
        l = r;
        r = t;
    end
    return {l, r};
endfunction

// Number of pairs whose combined masked parity is one
function automatic logic [23:0] tally_model(input logic [31:0] seed, input logic [31:0] poly,
                                            input logic [31:0] mi, input logic [31:0] mo,
                                            input logic [23:0] m, input int rounds,
                                            input logic [63:0] key);
    int unsigned n;
    logic [31:0] p;
    logic [31:0] c;
    logic [23:0] hits;
    n    = (m == 24'd0) ? 32'd16777216 : {8'd0, m};    // Zero means 2^24 messages
    p    = seed;
    hits = '0;
    for (int unsigned k = 0; k < n; k++) begin
        c = encrypt_block(p, rounds, key);
        if ((^(p & mi)) != (^(c & mo))) begin
            hits = hits + 24'd1;
        end
        p = galois_next(p, poly);
    end
    return hits;
endfunction

// Plaintexts with bit 0 set, from the LFSR alone
function automatic logic [23:0] odd_plaintexts(input logic [31:0] seed, input logic [31:0] poly,
                                               input logic [23:0] m);
    logic [31:0] p;
    logic [23:0] ones;
    p    = seed;
    ones = '0;
    for (int unsigned k = 0; k < {8'd0, m}; k++) begin
        ones = ones + {23'd0, p[0]};
        p    = galois_next(p, poly);
    end
    return ones;
endfunction

`endif

//--- tests/tb_lca.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lca;

    localparam int          ROUNDS = 4;
    localparam logic [63:0] KEY    = 64'h0123_4567_89ab_cdef;
    localparam int          NROWS  = 6;

    typedef struct {
        lca_pkg::block_t seed;
        lca_pkg::block_t poly;
        lca_pkg::block_t mask_in;
        lca_pkg::block_t mask_out;
        lca_pkg::count_t msg_count;
        lca_pkg::count_t exp_count;                      // Expected tally
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic            restart;
    lca_pkg::block_t seed;
    lca_pkg::block_t poly;
    lca_pkg::block_t mask_in;
    lca_pkg::block_t mask_out;
    lca_pkg::count_t msg_count;
    lca_pkg::count_t count;
    logic            done;

    row_t        table_rows [NROWS];
    logic [31:0] fib_state;                              // Stimulus LFSR
    int          checks;
    int          errors;
    int          timeouts;

    `include "lca_ref.svh"

    lca_top #(
        .ROUNDS (ROUNDS),
        .KEY    (KEY)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .restart   (restart),
        .seed      (seed),
        .poly      (poly),
        .mask_in   (mask_in),
        .mask_out  (mask_out),
        .msg_count (msg_count),
        .count     (count),
        .done      (done)
    );

    always #20 clk = ~clk;                               // 40 ns period

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_rand_bit();
        logic fb;
        fb        = fib_state[31] ^ fib_state[21] ^ fib_state[1] ^ fib_state[0];
        fib_state = {fib_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], next_rand_bit()};              // One step per bit
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic fill_table();
        row_t r;
        table_rows[0] = '{32'h0000_0001, 32'h8020_0003, 32'h0000_0001, 32'h8000_0000, 24'd16, 24'd0};
        table_rows[1] = '{32'hdead_beef, 32'hd000_0001, 32'h0f0f_0000, 32'h0000_00ff, 24'd1, 24'd0};
        for (int i = 2; i < 4; i++) begin
            r.seed        = random_word() | 32'h1;       // Keep the LFSR off all zeros
            r.poly        = (i == 2) ? 32'h8020_0003 : 32'hd000_0001;
            r.mask_in     = random_word();
            r.mask_out    = random_word();
            r.msg_count   = (i == 2) ? 24'd100 : 24'd37;
            r.exp_count   = '0;
            table_rows[i] = r;
        end
        for (int i = 0; i < 4; i++) begin
            r = table_rows[i];
            table_rows[i].exp_count = tally_model(r.seed, r.poly, r.mask_in, r.mask_out,
                                                  r.msg_count, ROUNDS, KEY);
        end
        table_rows[4] = '{random_word() | 32'h1, 32'h8020_0003, 32'h0, 32'h0, 24'd50, 24'd0};
        table_rows[5] = '{32'h1357_9bdf, 32'hd000_0001, 32'h1, 32'h0, 24'd64, 24'd0};
        table_rows[5].exp_count = odd_plaintexts(32'h1357_9bdf, 32'hd000_0001, 24'd64);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                              // Drive and sample past the edge
    endtask

    task automatic drive_row(input row_t r);
        seed      = r.seed;
        poly      = r.poly;
        mask_in   = r.mask_in;
        mask_out  = r.mask_out;
        msg_count = r.msg_count;
        start     = 1'b1;
    endtask

    // Start one run, then check done latency and final count
    task automatic run_row(input int idx);
        row_t r;
        int   cycles;
        int   limit;
        r = table_rows[idx];
        next_cycle();
        drive_row(r);
        limit  = int'(r.msg_count) + ROUNDS + 50;
        cycles = 0;
        do begin
            next_cycle();
            start = 1'b0;
            cycles++;
        end while (!done && cycles < limit);
        if (!done) begin
            timeouts++;
            $display("Timeout: row %0d did not raise done within %0d cycles", idx, limit);
        end else begin
            check_value("done_latency", 32'(cycles), 32'(int'(r.msg_count) + ROUNDS + 1));
            check_value("count", 32'(count), 32'(r.exp_count));
        end
    endtask

    // A start pulse while done is high changes nothing
    task automatic start_ignored();
        lca_pkg::count_t held;
        held  = count;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (ROUNDS + 4) next_cycle();
        check_value("done", 32'(done), 32'h1);
        check_value("count", 32'(count), 32'(held));
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
        check_value("done", 32'(done), 32'h0);           // Cleared on the very next cycle
        check_value("count", 32'(count), 32'h0);
    endtask

    task automatic abort_midway(input int idx);
        next_cycle();
        drive_row(table_rows[idx]);
        next_cycle();
        start = 1'b0;
        repeat (int'(table_rows[idx].msg_count) / 2) next_cycle();
        check_value("done", 32'(done), 32'h0);           // Run still in progress
        pulse_restart();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        restart   = 1'b0;
        seed      = '0;
        poly      = '0;
        mask_in   = '0;
        mask_out  = '0;
        msg_count = '0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        fib_state = 32'h6f8f6ea1;
        fill_table();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("done", 32'(done), 32'h0);
        check_value("count", 32'(count), 32'h0);
        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
            start_ignored();
            pulse_restart();
        end
        abort_midway(2);
        run_row(3);                                      // Clean run after the abort
        pulse_restart();
        $display("Checks: %0d errors: %0d timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
rtl/lca_pkg.sv
rtl/pair_if.sv
rtl/lca_ctrl.sv
rtl/msg_source.sv
rtl/feistel_pipe.sv
rtl/parity_tally.sv
rtl/lca_top.sv
tests/tb_lca.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_lca \
    && ./obj_dir/Vtb_lca > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
